// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= pfir_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only if the simulation printed the pass line
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/pfir_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pfir_assert (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic sample_en,
   input wire logic dout_valid
);

   // capture edge to the edge where dout_valid is first seen high
   localparam int PULSE_DELAY = pfir_pkg::BANK_LEN + 2;

   logic [2:0] since_rst;
   int         assert_fails = 0;

   // cycles since reset released, saturating
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         since_rst <= '0;
      end else if (since_rst != 3'd7) begin
         since_rst <= since_rst + 3'd1;
      end
   end

   a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      dout_valid |=> !dout_valid)
   else begin
      assert_fails++;
      $error("dout_valid high for two cycles in a row");
   end

   a_quiet_after_reset: assert property (@(posedge clk)
      (rst_n && since_rst < 3'd5) |-> !dout_valid)
   else begin
      assert_fails++;
      $error("dout_valid high within 5 cycles of reset");
   end

   // sample captured 5 cycles before the pulse began
   a_pulse_source: assert property (@(posedge clk) disable iff (!rst_n)
      dout_valid |-> $past(sample_en, PULSE_DELAY))
   else begin
      assert_fails++;
      $error("dout_valid without a sample 5 cycles earlier");
   end

endmodule

bind pfir_decimator pfir_assert i_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .sample_en  (sample_en),
   .dout_valid (dout_valid)
);

`default_nettype wire

// File: bench/pfir_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pfir_tb;

   import pfir_pkg::*;

   // output pulse follows the capturing edge by this many cycles
   localparam int LATENCY     = BANK_LEN + 1;
   localparam int GAP_MIN     = BANK_LEN + 2;
   localparam int GAP_SPAN    = 4;
   localparam int DRAIN_LIMIT = 120;
   localparam int RAND_BLOCKS = 40;

   localparam longint  LIM_HI   = (longint'(1) << (OUT_W - 1)) - 1;
   localparam longint  LIM_LO   = -(longint'(1) << (OUT_W - 1));
   localparam sample_t FULL_POS = sample_t'((1 << (SAMPLE_W - 1)) - 1);
   localparam sample_t FULL_NEG = sample_t'(-(1 << (SAMPLE_W - 1)));

   logic    clk;
   logic    rst_n;
   logic    sample_en;
   sample_t din;
   out_t    dout;
   logic    dout_valid;

   logic [31:0] rng_state = 32'h9a7d0a2c;
   int          cycle = 0;
   int          errors = 0;
   int          checks = 0;
   int          mon_errors = 0;
   int          mon_checks = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          pulses = 0;
   int          nsamp = 0;
   int          hist [$];
   out_t        exp_val [$];
   int          exp_due [$];

   pfir_decimator i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .sample_en  (sample_en),
      .din        (din),
      .dout       (dout),
      .dout_valid (dout_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // floor divide, nearest with ties to even, then clip
   function automatic out_t round_sat(input longint sum);
      longint scale;
      longint q;
      longint r;
      scale = longint'(1) << FRAC_SHIFT;
      q = sum / scale;
      if (q * scale > sum) begin
         q = q - 1;
      end
      r = sum - q * scale;
      if ((2 * r > scale) || ((2 * r == scale) && (q % 2 != 0))) begin
         q = q + 1;
      end
      if (q > LIM_HI) begin
         return out_t'(LIM_HI);
      end
      if (q < LIM_LO) begin
         return out_t'(LIM_LO);
      end
      return out_t'(q);
   endfunction

   // hist[k] is x[n-k], missing history counts as zero
   function automatic out_t ref_output();
      longint acc = 0;
      for (int k = 0; k < N_TAPS && k < hist.size(); k++) begin
         acc += longint'(COEF_TABLE[k]) * longint'(hist[k]);
      end
      return round_sat(acc);
   endfunction

   // reference model and pulse checker
   always @(negedge clk) begin
      int due;
      if (rst_n) begin
         if (sample_en) begin
            hist.push_front(int'(din));
            if (hist.size() > N_TAPS) begin
               void'(hist.pop_back());
            end
            nsamp++;
            if (nsamp % DECIM == 0) begin
               exp_val.push_back(ref_output());
               // captured at the next rising edge
               exp_due.push_back(cycle + 1 + LATENCY);
            end
         end
         if (dout_valid) begin
            pulses++;
            if (exp_val.size() == 0) begin
               $display("[%0t] unexpected dout_valid pulse with no closed block", $time);
               mon_errors++;
            end else begin
               mon_checks++;
               due = exp_due.pop_front();
               assert (dout == exp_val[0]) else begin
                  $display("MISMATCH at %0t: dout expected %0d, got %0d",
                           $time, exp_val[0], dout);
                  mon_errors++;
               end
               void'(exp_val.pop_front());
               assert (cycle == due) else begin
                  $display("[%0t] dout_valid came at cycle %0d instead of cycle %0d",
                           $time, cycle, due);
                  mon_errors++;
               end
            end
         end else if (exp_due.size() > 0 && cycle > exp_due[0]) begin
            $display("[%0t] dout_valid pulse missing, it was due at cycle %0d",
                     $time, exp_due[0]);
            mon_errors++;
            void'(exp_due.pop_front());
            void'(exp_val.pop_front());
         end
      end
   end

   task automatic check_value(input string what, input out_t exp, input out_t act);
      checks++;
      assert (act == exp) else begin
         $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_int(input string what, input int exp, input int act);
      checks++;
      assert (act == exp) else begin
         $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, what, exp, act);
         errors++;
      end
   endtask

   task automatic send_sample(input sample_t value);
      int gap;
      gap = GAP_MIN + int'(next_random() % GAP_SPAN);
      @(posedge clk);
      sample_en <= 1'b1;
      din       <= value;
      @(posedge clk);
      sample_en <= 1'b0;
      repeat (gap - 2) @(posedge clk);
   endtask

   // full-scale samples, oldest first, signs matched to the taps
   task automatic send_full_scale(input bit invert);
      for (int k = N_TAPS - 1; k >= 0; k--) begin
         if ((COEF_TABLE[k] < 0) ^ invert) begin
            send_sample(FULL_NEG);
         end else begin
            send_sample(FULL_POS);
         end
      end
   endtask

   task automatic wait_outputs();
      int waited;
      waited = 0;
      while (exp_val.size() > 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_val.size() > 0) begin
         $display("[%0t] timeout, %0d output pulse(s) still outstanding",
                  $time, exp_val.size());
         errors++;
      end
      @(posedge clk);
   endtask

   task automatic report_test(input string name, input int err_start);
      int err_now;
      err_now = errors + mon_errors;
      tests_run++;
      if (err_now == err_start) begin
         $display("[%0t] test %s: pass", $time, name);
      end else begin
         tests_failed++;
         $display("[%0t] test %s: FAIL, %0d error(s)", $time, name, err_now - err_start);
      end
   endtask

   initial begin
      int err_start;
      int start_pulses;
      rst_n     = 1'b0;
      sample_en = 1'b0;
      din       = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      // quiet after reset and through a partial block
      err_start = errors + mon_errors;
      repeat (8) @(posedge clk);
      for (int i = 0; i < DECIM - 1; i++) begin
         send_sample(sample_t'(100 * (i + 1)));
      end
      repeat (10) @(posedge clk);
      check_int("pulses before first block", 0, pulses);
      report_test("reset_quiet", err_start);

      // one pulse per closed block
      err_start = errors + mon_errors;
      start_pulses = pulses;
      for (int i = 0; i < DECIM + 1; i++) begin
         send_sample(sample_t'(next_random()));
      end
      wait_outputs();
      check_int("pulses for two blocks", 2, pulses - start_pulses);
      report_test("block_timing", err_start);

      // impulse walks through every fourth tap
      err_start = errors + mon_errors;
      for (int i = 0; i < N_TAPS; i++) begin
         send_sample('0);
      end
      wait_outputs();
      for (int blk = 0; blk < BANK_LEN; blk++) begin
         for (int i = 0; i < DECIM; i++) begin
            send_sample((blk == 0 && i == 0) ? sample_t'(1024) : sample_t'(0));
         end
         wait_outputs();
         check_value("impulse tap", round_sat(1024 * longint'(COEF_TABLE[3 + DECIM * blk])),
                     dout);
      end
      report_test("impulse", err_start);

      err_start = errors + mon_errors;
      start_pulses = pulses;
      for (int i = 0; i < RAND_BLOCKS * DECIM; i++) begin
         send_sample(sample_t'(next_random()));
      end
      wait_outputs();
      check_int("pulses for random blocks", RAND_BLOCKS, pulses - start_pulses);
      report_test("random", err_start);

      err_start = errors + mon_errors;
      send_full_scale(1'b0);
      wait_outputs();
      check_value("positive clip", out_t'(LIM_HI), dout);
      send_full_scale(1'b1);
      wait_outputs();
      check_value("negative clip", out_t'(LIM_LO), dout);
      report_test("saturation", err_start);

      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests_run, tests_failed, checks + mon_checks, errors + mon_errors,
               i_dut.i_assert.assert_fails);
      if (errors == 0 && mon_errors == 0 && tests_failed == 0 &&
          i_dut.i_assert.assert_fails == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/pfir_bank.sv
`timescale 1ns/1ps
`default_nettype none

module pfir_bank #(
   parameter int PHASE = 0
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        we,
   input  pfir_pkg::sample_t           din,
   input  logic [pfir_pkg::TAP_W-1:0]  tap_idx,
   input  logic                        mac_first,
   input  logic                        mac_en,
   output pfir_pkg::acc_t              acc
);

   import pfir_pkg::*;

   sample_t dline [BANK_LEN];
   coef_t   coef;
   acc_t    prod;

   // delay line, entry 0 is the newest sample of this phase
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < BANK_LEN; i++) begin
            dline[i] <= '0;
         end
      end else if (we) begin
         dline[0] <= din;
         for (int i = 1; i < BANK_LEN; i++) begin
            dline[i] <= dline[i-1];
         end
      end
   end

   // tap j of this phase is filter tap PHASE + j*DECIM
   assign coef = COEF_TABLE[PHASE + DECIM * int'(tap_idx)];

   // full-width product, no rounding inside the bank
   assign prod = acc_t'(dline[tap_idx]) * acc_t'(coef);

   // multiply-accumulate
   // first tap loads so no separate clear cycle is needed
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (mac_en) begin
         if (mac_first) begin
            acc <= prod;
         end else begin
            acc <= acc + prod;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/pfir_control.sv
`timescale 1ns/1ps
`default_nettype none

module pfir_control (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        sample_en,
   output logic [pfir_pkg::DECIM-1:0]  bank_we,
   output logic [pfir_pkg::TAP_W-1:0]  tap_idx,
   output logic                        mac_first,
   output logic                        mac_en,
   output logic                        sum_en
);

   import pfir_pkg::*;

   logic [PHASE_W-1:0] phase;
   logic               block_close;
   seq_state_t         state;

   // last sample of a block, it goes to bank 0
   assign block_close = sample_en && (phase == PHASE_W'(DECIM - 1));

   // phase counter, one step per input sample
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase <= '0;
      end else if (sample_en) begin
         if (block_close) begin
            phase <= '0;
         end else begin
            phase <= phase + 1'b1;
         end
      end
   end

   // commutator runs from the top bank down
   // phase c writes bank DECIM-1-c
   always_comb begin
      bank_we = '0;
      bank_we[DECIM - 1 - int'(phase)] = sample_en;
   end

   // sequencer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= SEQ_IDLE;
         tap_idx <= '0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (block_close) begin
                  state   <= SEQ_MAC;
                  tap_idx <= '0;
               end
            end
            SEQ_MAC: begin
               if (tap_idx == TAP_W'(BANK_LEN - 1)) begin
                  state <= SEQ_SUM;
               end else begin
                  tap_idx <= tap_idx + 1'b1;
               end
            end
            SEQ_SUM: begin
               state <= SEQ_IDLE;
            end
            default: begin
               state <= SEQ_IDLE;
            end
         endcase
      end
   end

   // strobes decoded from the state
   assign mac_en    = (state == SEQ_MAC);
   assign mac_first = mac_en && (tap_idx == '0);
   assign sum_en    = (state == SEQ_SUM);

endmodule

`default_nettype wire

// File: source/pfir_decimator.sv
`timescale 1ns/1ps
`default_nettype none

// polyphase decimating FIR, one output per DECIM input samples
// sample_en pulses must be at least BANK_LEN + 2 clocks apart,
// nothing in the design checks this
module pfir_decimator (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               sample_en,
   input  pfir_pkg::sample_t  din,
   output pfir_pkg::out_t     dout,
   output logic               dout_valid
);

   import pfir_pkg::*;

   logic [DECIM-1:0] bank_we;
   logic [TAP_W-1:0] tap_idx;
   logic             mac_first;
   logic             mac_en;
   logic             sum_en;
   acc_t             bank_acc [DECIM];

   pfir_control i_control (
      .clk       (clk),
      .rst_n     (rst_n),
      .sample_en (sample_en),
      .bank_we   (bank_we),
      .tap_idx   (tap_idx),
      .mac_first (mac_first),
      .mac_en    (mac_en),
      .sum_en    (sum_en)
   );

   // din goes to every bank, bank_we picks the one that stores it
   for (genvar p = 0; p < DECIM; p++) begin : g_bank
      pfir_bank #(
         .PHASE (p)
      ) i_bank (
         .clk       (clk),
         .rst_n     (rst_n),
         .we        (bank_we[p]),
         .din       (din),
         .tap_idx   (tap_idx),
         .mac_first (mac_first),
         .mac_en    (mac_en),
         .acc       (bank_acc[p])
      );
   end

   pfir_output i_output (
      .clk        (clk),
      .rst_n      (rst_n),
      .sum_en     (sum_en),
      .bank_acc0  (bank_acc[0]),
      .bank_acc1  (bank_acc[1]),
      .bank_acc2  (bank_acc[2]),
      .bank_acc3  (bank_acc[3]),
      .dout       (dout),
      .dout_valid (dout_valid)
   );

endmodule

`default_nettype wire

// File: source/pfir_output.sv
`timescale 1ns/1ps
`default_nettype none

module pfir_output (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            sum_en,
   input  pfir_pkg::acc_t  bank_acc0,
   input  pfir_pkg::acc_t  bank_acc1,
   input  pfir_pkg::acc_t  bank_acc2,
   input  pfir_pkg::acc_t  bank_acc3,
   output pfir_pkg::out_t  dout,
   output logic            dout_valid
);

   import pfir_pkg::*;

   acc_t                  sum;
   acc_t                  quot;
   logic [FRAC_SHIFT-1:0] frac;
   logic                  round_up;
   acc_t                  rounded;
   out_t                  sat_val;

   // sum of all phase banks
   assign sum = bank_acc0 + bank_acc1 + bank_acc2 + bank_acc3;

   // floor division by 2^FRAC_SHIFT plus the dropped fraction
   assign quot = sum >>> FRAC_SHIFT;
   assign frac = sum[FRAC_SHIFT-1:0];

   // convergent rounding
   // above half always rounds up, exactly half only when quot is odd
   assign round_up = frac[FRAC_SHIFT-1] && ((|frac[FRAC_SHIFT-2:0]) || quot[0]);
   assign rounded  = quot + acc_t'(round_up);

   // clip to the output range
   always_comb begin
      if (rounded > acc_t'(OUT_MAX)) begin
         sat_val = OUT_MAX;
      end else if (rounded < acc_t'(OUT_MIN)) begin
         sat_val = OUT_MIN;
      end else begin
         sat_val = out_t'(rounded);
      end
   end

   // dout holds between valid pulses
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dout       <= '0;
         dout_valid <= 1'b0;
      end else begin
         dout_valid <= sum_en;
         if (sum_en) begin
            dout <= sat_val;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/pfir_pkg.sv
`default_nettype none

package pfir_pkg;

   // phase banks and taps per bank
   localparam int DECIM    = 4;
   localparam int BANK_LEN = 4;
   localparam int N_TAPS   = DECIM * BANK_LEN;

   // counter widths, sized for DECIM and BANK_LEN
   localparam int PHASE_W = 2;
   localparam int TAP_W   = 2;

   // datapath widths
   localparam int SAMPLE_W = 12;
   localparam int COEF_W   = 16;
   localparam int ACC_W    = 32;
   localparam int OUT_W    = 14;

   // coefficient fraction bits, dropped on the way out
   localparam int FRAC_SHIFT = 15;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [COEF_W-1:0]   coef_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic signed [OUT_W-1:0]    out_t;

   // output clip limits
   localparam out_t OUT_MAX = {1'b0, {(OUT_W - 1){1'b1}}};
   localparam out_t OUT_MIN = {1'b1, {(OUT_W - 1){1'b0}}};

   // symmetric lowpass in Q1.15, entry k is h[k]
   // gain is well above unity, so full-scale input clips the output
   localparam coef_t COEF_TABLE [N_TAPS] = '{
      -16'sd1200,
      -16'sd2400,
       16'sd0,
       16'sd6000,
       16'sd14000,
       16'sd22000,
       16'sd28000,
       16'sd32000,
       16'sd32000,
       16'sd28000,
       16'sd22000,
       16'sd14000,
       16'sd6000,
       16'sd0,
      -16'sd2400,
      -16'sd1200
   };

   // sequencer states
   //  SEQ_IDLE waiting for a block to close
   //  SEQ_MAC  one cycle per tap, all banks in parallel
   //  SEQ_SUM  bank results summed into the output register
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_MAC,
      SEQ_SUM
   } seq_state_t;

endpackage

`default_nettype wire

// File: vlog.f
source/pfir_pkg.sv
source/pfir_control.sv
source/pfir_bank.sv
source/pfir_output.sv
source/pfir_decimator.sv
bench/pfir_assert.sv
bench/pfir_tb.sv
